/* hw/thermal_config.svh */
`ifndef THERMAL_CONFIG_SVH
`define THERMAL_CONFIG_SVH

// Link geometry
`define NUM_LANES       8
`define NUM_ZONES       2
`define LANES_PER_ZONE  4   // Zone z covers lanes 4z..4z+3

// Temperature limits, 0.1 C units
`define TEMP_WARNING        850
`define TEMP_CRITICAL       1050
`define THERMAL_HYSTERESIS  50
`define EMERGENCY_MARGIN    100   // Above critical

// Thermal resistance in 0.1 C per mW
`define R_TH_X10  5

// Corner power scaling in percent of reported power
`define SS_DERATE_PCT  120
`define FF_DERATE_PCT  85

// Shortest time a lane stays throttled
`define THROTTLE_MIN_CYCLES  256

`endif

/* hw/thermal_pkg.sv */
package thermal_pkg;

    // Temperature in 0.1 C steps, so 850 is 85.0 C
    typedef logic [15:0] temperature_t;

    // Per-lane output of the thermal model
    typedef struct packed {
        temperature_t temp;
        logic         alarm;      // Warning level with hysteresis
        logic         critical;   // Critical level with hysteresis
    } lane_thermal_t;

endpackage

/* hw/power_pkg.sv */
package power_pkg;

    // Lane power in mW
    typedef logic [15:0] power_mw_t;

    // Process corner as reported by the die; code 3 is treated as TT
    typedef enum logic [1:0] {
        CORNER_SS = 2'd0,
        CORNER_TT = 2'd1,
        CORNER_FF = 2'd2
    } corner_t;

    // Power scaling command sent to one lane
    typedef struct packed {
        logic       active;
        logic [7:0] scale_factor;   // 255 is full power
        logic [3:0] voltage_level;
        logic [3:0] freq_div;
    } throttle_cmd_t;

endpackage

/* hw/power_derate.sv */
`timescale 1ns/100ps
`include "thermal_config.svh"

module power_derate
    import power_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [`NUM_LANES-1:0] lane_en,
    input  corner_t               corner,
    input  power_mw_t             lane_power [`NUM_LANES-1:0],
    output power_mw_t             eff_power  [`NUM_LANES-1:0],
    output power_mw_t             raw_power  [`NUM_LANES-1:0]
);

    logic [6:0] derate_pct;

    always_comb begin
        case (corner)
            CORNER_SS: derate_pct = 7'(`SS_DERATE_PCT);
            CORNER_FF: derate_pct = 7'(`FF_DERATE_PCT);
            default:   derate_pct = 7'd100;   // TT and unused code
        endcase
    end

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        logic [22:0] scaled;

        assign scaled = 23'(lane_power[i]) * 23'(derate_pct);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                eff_power[i] <= '0;
                raw_power[i] <= '0;
            end else if (enable && lane_en[i]) begin
                eff_power[i] <= power_mw_t'(scaled / 23'd100);   // Truncating divide
                raw_power[i] <= lane_power[i];
            end
        end

        // Worst corner adds 20 %, so the derated value can never go past that
        a_derate_bound: assert property (@(posedge clk) disable iff (!rst_n)
            24'(eff_power[i]) * 24'd100 <= 24'(raw_power[i]) * 24'(`SS_DERATE_PCT))
            else $error("lane %0d derated power above SS bound", i);
    end

endmodule

/* hw/lane_thermal_model.sv */
`timescale 1ns/100ps
`include "thermal_config.svh"

module lane_thermal_model
    import thermal_pkg::*;
    import power_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [`NUM_LANES-1:0] lane_en,
    input  temperature_t          ambient,
    input  power_mw_t             eff_power    [`NUM_LANES-1:0],
    output lane_thermal_t         lane_thermal [`NUM_LANES-1:0]
);

    localparam temperature_t WARN_SET  = temperature_t'(`TEMP_WARNING);
    localparam temperature_t WARN_CLR  = temperature_t'(`TEMP_WARNING - `THERMAL_HYSTERESIS);
    localparam temperature_t CRIT_SET  = temperature_t'(`TEMP_CRITICAL);
    localparam temperature_t CRIT_CLR  = temperature_t'(`TEMP_CRITICAL - `THERMAL_HYSTERESIS);

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        temperature_t old_temp;
        logic [20:0]  target;   // Steady-state temperature for this power
        logic [20:0]  blend;

        assign old_temp = lane_thermal[i].temp;
        assign target   = 21'(ambient) + 21'(eff_power[i]) * 21'(`R_TH_X10);

        // First-order low pass, new = (7 * old + target) / 8
        assign blend = 21'(old_temp) * 21'd7 + target;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                lane_thermal[i].temp     <= ambient;
                lane_thermal[i].alarm    <= 1'b0;
                lane_thermal[i].critical <= 1'b0;
            end else if (enable && lane_en[i]) begin
                lane_thermal[i].temp <= temperature_t'(blend >> 3);

                // Flags look at the temperature before this update
                if (old_temp > WARN_SET) begin
                    lane_thermal[i].alarm <= 1'b1;
                end else if (old_temp < WARN_CLR && !(old_temp > CRIT_SET)) begin
                    lane_thermal[i].alarm <= 1'b0;
                end

                if (old_temp > CRIT_SET) begin
                    lane_thermal[i].critical <= 1'b1;
                end else if (old_temp < CRIT_CLR) begin
                    lane_thermal[i].critical <= 1'b0;
                end
            end
        end

        // Critical band sits inside the warning band
        a_crit_has_alarm: assert property (@(posedge clk) disable iff (!rst_n)
            lane_thermal[i].critical |-> lane_thermal[i].alarm)
            else $error("lane %0d critical without alarm", i);
    end

endmodule

/* hw/throttle_ctrl.sv */
`timescale 1ns/100ps
`include "thermal_config.svh"

module throttle_ctrl
    import thermal_pkg::*;
    import power_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [`NUM_LANES-1:0] lane_en,
    input  logic                  global_throttle_en,
    input  logic [7:0]            throttle_on_temp,    // Whole degrees
    input  logic [7:0]            throttle_off_temp,
    input  lane_thermal_t         lane_thermal [`NUM_LANES-1:0],
    output throttle_cmd_t         cmd          [`NUM_LANES-1:0]
);

    // Full power, nominal voltage
    localparam throttle_cmd_t CMD_IDLE = '{active: 1'b0, scale_factor: 8'hFF,
                                           voltage_level: 4'd8, freq_div: 4'd1};
    // About 75 % power
    localparam throttle_cmd_t CMD_WARN = '{active: 1'b1, scale_factor: 8'hC0,
                                           voltage_level: 4'd7, freq_div: 4'd1};
    // Half power and half clock
    localparam throttle_cmd_t CMD_CRIT = '{active: 1'b1, scale_factor: 8'h80,
                                           voltage_level: 4'd6, freq_div: 4'd2};
    localparam logic [15:0]   HOLD_MIN = 16'(`THROTTLE_MIN_CYCLES);

    temperature_t on_thresh;
    temperature_t off_thresh;

    assign on_thresh  = temperature_t'(throttle_on_temp) * 16'd10;   // To 0.1 C units
    assign off_thresh = temperature_t'(throttle_off_temp) * 16'd10;

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        logic [15:0] hold_cnt;
        logic        engage;
        logic        release_ok;

        assign engage = !cmd[i].active &&
                        (lane_thermal[i].alarm ||
                         (global_throttle_en && lane_thermal[i].temp > on_thresh));
        assign release_ok = lane_thermal[i].temp < off_thresh && hold_cnt > HOLD_MIN;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                cmd[i]   <= CMD_IDLE;
                hold_cnt <= '0;
            end else if (enable && lane_en[i]) begin
                if (engage) begin
                    cmd[i]   <= lane_thermal[i].critical ? CMD_CRIT : CMD_WARN;
                    hold_cnt <= '0;
                end else if (cmd[i].active) begin
                    hold_cnt <= hold_cnt + 16'd1;
                    if (release_ok) begin
                        cmd[i] <= CMD_IDLE;
                    end
                end
            end
        end

        a_idle_full_scale: assert property (@(posedge clk) disable iff (!rst_n)
            cmd[i].active == (cmd[i].scale_factor != 8'hFF))
            else $error("lane %0d scale factor does not match throttle state", i);
    end

endmodule

/* hw/thermal_aggregate.sv */
`timescale 1ns/100ps
`include "thermal_config.svh"

module thermal_aggregate
    import thermal_pkg::*;
    import power_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [`NUM_LANES-1:0] lane_en,
    input  temperature_t          ambient,
    input  lane_thermal_t         lane_thermal [`NUM_LANES-1:0],
    input  power_mw_t             raw_power    [`NUM_LANES-1:0],
    input  temperature_t          zone_temp    [`NUM_ZONES-1:0],
    output logic [`NUM_ZONES-1:0] zone_alarm,
    output logic [`NUM_ZONES-1:0] zone_critical,
    output logic                  system_alarm,
    output logic                  emergency_req,
    output temperature_t          max_temp,
    output power_mw_t             total_power
);

    localparam temperature_t WARN_LVL  = temperature_t'(`TEMP_WARNING);
    localparam temperature_t CRIT_LVL  = temperature_t'(`TEMP_CRITICAL);
    localparam temperature_t EMERG_LVL = temperature_t'(`TEMP_CRITICAL + `EMERGENCY_MARGIN);

    temperature_t zone_max_d [`NUM_ZONES-1:0];
    temperature_t zone_max_q [`NUM_ZONES-1:0];
    temperature_t max_temp_d;
    power_mw_t    power_sum_d;

    // Per-zone maximum falls back to ambient when the zone has no enabled lane
    always_comb begin
        logic         seen;
        temperature_t best;
        int           idx;
        for (int z = 0; z < `NUM_ZONES; z++) begin
            seen = 1'b0;
            best = ambient;
            for (int l = 0; l < `LANES_PER_ZONE; l++) begin
                idx = z * `LANES_PER_ZONE + l;
                if (lane_en[idx] && (!seen || lane_thermal[idx].temp > best)) begin
                    best = lane_thermal[idx].temp;
                    seen = 1'b1;
                end
            end
            zone_max_d[z] = best;
        end
    end

    always_comb begin
        logic seen;
        seen        = 1'b0;
        max_temp_d  = ambient;
        power_sum_d = '0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            if (lane_en[l]) begin
                power_sum_d = power_sum_d + raw_power[l];   // Wraps at 16 bits
                if (!seen || lane_thermal[l].temp > max_temp_d) begin
                    max_temp_d = lane_thermal[l].temp;
                end
                seen = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int z = 0; z < `NUM_ZONES; z++) begin
                zone_max_q[z] <= ambient;
            end
            max_temp    <= ambient;
            total_power <= '0;
        end else if (enable) begin
            zone_max_q  <= zone_max_d;
            max_temp    <= max_temp_d;
            total_power <= power_sum_d;
        end
    end

    // External zone sensors can raise the flags on their own
    for (genvar z = 0; z < `NUM_ZONES; z++) begin : g_zone
        assign zone_alarm[z]    = zone_max_q[z] > WARN_LVL || zone_temp[z] > WARN_LVL;
        assign zone_critical[z] = zone_max_q[z] > CRIT_LVL || zone_temp[z] > CRIT_LVL;
    end

    assign system_alarm  = |zone_alarm || max_temp > WARN_LVL;
    assign emergency_req = |zone_critical || max_temp > EMERG_LVL;   // 115.0 C

    // A lane above critical reaches the shutdown request through its own zone
    a_crit_forces_shutdown: assert property (@(posedge clk) disable iff (!rst_n)
        max_temp > CRIT_LVL |-> emergency_req)
        else $error("max temperature above critical without emergency request");

endmodule

/* hw/thermal_manager_top.sv */
`timescale 1ns/100ps
`include "thermal_config.svh"

module thermal_manager_top
    import thermal_pkg::*;
    import power_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  thermal_enable,
    input  logic [`NUM_LANES-1:0] lane_enable,
    input  corner_t               corner,
    input  temperature_t          ambient_temperature,
    input  power_mw_t             lane_power       [`NUM_LANES-1:0],
    input  temperature_t          zone_temperature [`NUM_ZONES-1:0],
    input  logic                  global_throttle_enable,
    input  logic [7:0]            throttle_on_temp,
    input  logic [7:0]            throttle_off_temp,
    output lane_thermal_t         lane_thermal     [`NUM_LANES-1:0],
    output throttle_cmd_t         throttle_cmd     [`NUM_LANES-1:0],
    output logic [`NUM_ZONES-1:0] zone_alarm,
    output logic [`NUM_ZONES-1:0] zone_critical,
    output logic                  system_alarm,
    output logic                  emergency_req,
    output temperature_t          max_temp,
    output power_mw_t             total_power
);

    power_mw_t eff_power [`NUM_LANES-1:0];
    power_mw_t raw_power [`NUM_LANES-1:0];   // Registered alongside eff_power

    power_derate u_power_derate (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (thermal_enable),
        .lane_en    (lane_enable),
        .corner     (corner),
        .lane_power (lane_power),
        .eff_power  (eff_power),
        .raw_power  (raw_power)
    );

    lane_thermal_model u_lane_thermal_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (thermal_enable),
        .lane_en      (lane_enable),
        .ambient      (ambient_temperature),
        .eff_power    (eff_power),
        .lane_thermal (lane_thermal)
    );

    throttle_ctrl u_throttle_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .enable             (thermal_enable),
        .lane_en            (lane_enable),
        .global_throttle_en (global_throttle_enable),
        .throttle_on_temp   (throttle_on_temp),
        .throttle_off_temp  (throttle_off_temp),
        .lane_thermal       (lane_thermal),
        .cmd                (throttle_cmd)
    );

    thermal_aggregate u_thermal_aggregate (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (thermal_enable),
        .lane_en       (lane_enable),
        .ambient       (ambient_temperature),
        .lane_thermal  (lane_thermal),
        .raw_power     (raw_power),
        .zone_temp     (zone_temperature),
        .zone_alarm    (zone_alarm),
        .zone_critical (zone_critical),
        .system_alarm  (system_alarm),
        .emergency_req (emergency_req),
        .max_temp      (max_temp),
        .total_power   (total_power)
    );

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS   = 20,
    parameter int RESET_TICKS = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        #(PERIOD_NS * RESET_TICKS + PERIOD_NS / 4) rst_n = 1'b1;   // Release away from an edge
    end

endmodule

/* sim/tb_thermal_manager.sv */
`timescale 1ns/100ps
`include "thermal_config.svh"

module tb_thermal_manager
    import thermal_pkg::*;
    import power_pkg::*;
;

    localparam int NUM_PHASES = 9;
    localparam int AMBIENT    = 250;

    typedef struct packed {
        corner_t                     corner;
        temperature_t                ambient;
        logic [`NUM_LANES-1:0]       lane_en;
        logic [`NUM_LANES-1:0][15:0] power;
        logic [`NUM_ZONES-1:0][15:0] zone;
        logic [7:0]                  on_temp;
        logic [7:0]                  off_temp;
        logic                        gte;
        logic                        ten;
        logic [15:0]                 cycles;
        logic                        exp_alarm0;   // Lane 0 alarm at phase end
        logic                        exp_sys;
        logic                        exp_emerg;
    } phase_t;

    logic                  clk;
    logic                  rst_n;
    logic                  thermal_enable;
    logic [`NUM_LANES-1:0] lane_enable;
    corner_t               corner;
    temperature_t          ambient_temperature;
    power_mw_t             lane_power       [`NUM_LANES-1:0];
    temperature_t          zone_temperature [`NUM_ZONES-1:0];
    logic                  global_throttle_enable;
    logic [7:0]            throttle_on_temp;
    logic [7:0]            throttle_off_temp;
    lane_thermal_t         lane_thermal     [`NUM_LANES-1:0];
    throttle_cmd_t         throttle_cmd     [`NUM_LANES-1:0];
    logic [`NUM_ZONES-1:0] zone_alarm;
    logic [`NUM_ZONES-1:0] zone_critical;
    logic                  system_alarm;
    logic                  emergency_req;
    temperature_t          max_temp;
    power_mw_t             total_power;

    phase_t phases [NUM_PHASES];
    int     cycle_errors;
    int     phase_errors;

    // Reference model state
    int            m_eff   [`NUM_LANES];
    int            m_raw   [`NUM_LANES];
    int            m_temp  [`NUM_LANES];
    bit            m_alarm [`NUM_LANES];
    bit            m_crit  [`NUM_LANES];
    throttle_cmd_t m_cmd   [`NUM_LANES];
    int            m_hold  [`NUM_LANES];
    int            m_zmax  [`NUM_ZONES];
    int            m_max;
    int            m_total;

    localparam throttle_cmd_t IDLE_CMD = '{1'b0, 8'hFF, 4'd8, 4'd1};
    localparam throttle_cmd_t WARN_CMD = '{1'b1, 8'hC0, 4'd7, 4'd1};
    localparam throttle_cmd_t CRIT_CMD = '{1'b1, 8'h80, 4'd6, 4'd2};

    tb_clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

    thermal_manager_top dut0 (.*);

    function automatic phase_t make_phase(corner_t c, logic [7:0] en, int pw, int z0, int z1,
                                          int on_t, int off_t, bit gte, bit ten, int cyc,
                                          bit ea, bit es, bit ee);
        phase_t p;
        p.corner  = c;
        p.ambient = 16'(AMBIENT);
        p.lane_en = en;
        for (int l = 0; l < `NUM_LANES; l++) begin
            p.power[l] = 16'(pw);
        end
        p.zone[0]    = 16'(z0);
        p.zone[1]    = 16'(z1);
        p.on_temp    = 8'(on_t);
        p.off_temp   = 8'(off_t);
        p.gte        = gte;
        p.ten        = ten;
        p.cycles     = 16'(cyc);
        p.exp_alarm0 = ea;
        p.exp_sys    = es;
        p.exp_emerg  = ee;
        return p;
    endfunction

    task automatic reset_model();
        for (int l = 0; l < `NUM_LANES; l++) begin
            m_eff[l]   = 0;
            m_raw[l]   = 0;
            m_temp[l]  = int'(ambient_temperature);
            m_alarm[l] = 1'b0;
            m_crit[l]  = 1'b0;
            m_cmd[l]   = IDLE_CMD;
            m_hold[l]  = 0;
        end
        for (int z = 0; z < `NUM_ZONES; z++) begin
            m_zmax[z] = int'(ambient_temperature);
        end
        m_max   = int'(ambient_temperature);
        m_total = 0;
    endtask

    // Stages run back to front so each reads its upstream value from before the edge
    task automatic step_model();
        int  best;
        int  pct;
        int  target;
        int  old_t;
        int  lane;
        bit  seen;
        for (int z = 0; z < `NUM_ZONES; z++) begin
            best = int'(ambient_temperature);
            seen = 1'b0;
            for (int k = 0; k < `LANES_PER_ZONE; k++) begin
                lane = z * `LANES_PER_ZONE + k;
                if (lane_enable[lane] && (!seen || m_temp[lane] > best)) begin
                    best = m_temp[lane];
                    seen = 1'b1;
                end
            end
            m_zmax[z] = best;
        end
        best    = int'(ambient_temperature);
        seen    = 1'b0;
        m_total = 0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            if (lane_enable[l]) begin
                m_total = (m_total + m_raw[l]) & 32'hFFFF;
                if (!seen || m_temp[l] > best) begin
                    best = m_temp[l];
                end
                seen = 1'b1;
            end
        end
        m_max = best;
        case (corner)
            CORNER_SS: pct = `SS_DERATE_PCT;
            CORNER_FF: pct = `FF_DERATE_PCT;
            default:   pct = 100;
        endcase
        for (int l = 0; l < `NUM_LANES; l++) begin
            if (lane_enable[l]) begin
                if (!m_cmd[l].active && (m_alarm[l] || (global_throttle_enable &&
                        m_temp[l] > int'(throttle_on_temp) * 10))) begin
                    m_cmd[l]  = m_crit[l] ? CRIT_CMD : WARN_CMD;
                    m_hold[l] = 0;
                end else if (m_cmd[l].active) begin
                    if (m_temp[l] < int'(throttle_off_temp) * 10 &&
                            m_hold[l] > `THROTTLE_MIN_CYCLES) begin
                        m_cmd[l] = IDLE_CMD;
                    end
                    m_hold[l] = (m_hold[l] + 1) & 32'hFFFF;
                end
                old_t     = m_temp[l];
                target    = int'(ambient_temperature) + m_eff[l] * `R_TH_X10;
                m_temp[l] = ((old_t * 7 + target) >> 3) & 32'hFFFF;
                if (old_t > `TEMP_WARNING) begin
                    m_alarm[l] = 1'b1;
                end else if (old_t < `TEMP_WARNING - `THERMAL_HYSTERESIS &&
                             !(old_t > `TEMP_CRITICAL)) begin
                    m_alarm[l] = 1'b0;
                end
                if (old_t > `TEMP_CRITICAL) begin
                    m_crit[l] = 1'b1;
                end else if (old_t < `TEMP_CRITICAL - `THERMAL_HYSTERESIS) begin
                    m_crit[l] = 1'b0;
                end
                m_eff[l] = ((int'(lane_power[l]) * pct) / 100) & 32'hFFFF;
                m_raw[l] = int'(lane_power[l]);
            end
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reset_model();
        end else if (thermal_enable) begin
            step_model();
        end
    end

    task automatic check_val(string name, int idx, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s[%0d] got 0x%0h expected 0x%0h at %0t", name, idx, got, exp,
                     $time);
            cycle_errors++;
        end
    endtask

    task automatic check_outputs();
        bit z_al;
        bit z_cr;
        bit any_al;
        bit any_cr;
        any_al = 1'b0;
        any_cr = 1'b0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            check_val("lane_temp", l, 32'(lane_thermal[l].temp), 32'(m_temp[l]));
            check_val("lane_alarm", l, 32'(lane_thermal[l].alarm), 32'(m_alarm[l]));
            check_val("lane_critical", l, 32'(lane_thermal[l].critical), 32'(m_crit[l]));
            check_val("throttle_cmd", l, 32'(throttle_cmd[l]), 32'(m_cmd[l]));
        end
        for (int z = 0; z < `NUM_ZONES; z++) begin
            z_al = m_zmax[z] > `TEMP_WARNING || int'(zone_temperature[z]) > `TEMP_WARNING;
            z_cr = m_zmax[z] > `TEMP_CRITICAL || int'(zone_temperature[z]) > `TEMP_CRITICAL;
            any_al |= z_al;
            any_cr |= z_cr;
            check_val("zone_alarm", z, 32'(zone_alarm[z]), 32'(z_al));
            check_val("zone_critical", z, 32'(zone_critical[z]), 32'(z_cr));
        end
        check_val("max_temp", 0, 32'(max_temp), 32'(m_max));
        check_val("total_power", 0, 32'(total_power), 32'(m_total));
        check_val("system_alarm", 0, 32'(system_alarm),
                  32'(any_al || m_max > `TEMP_WARNING));
        check_val("emergency_req", 0, 32'(emergency_req),
                  32'(any_cr || m_max > `TEMP_CRITICAL + `EMERGENCY_MARGIN));
    endtask

    task automatic apply_phase(phase_t p);
        thermal_enable         = p.ten;
        lane_enable            = p.lane_en;
        corner                 = p.corner;
        ambient_temperature    = p.ambient;
        global_throttle_enable = p.gte;
        throttle_on_temp       = p.on_temp;
        throttle_off_temp      = p.off_temp;
        for (int l = 0; l < `NUM_LANES; l++) begin
            lane_power[l] = p.power[l] + 16'($urandom % 4);   // Up to 3 mW jitter
        end
        for (int z = 0; z < `NUM_ZONES; z++) begin
            zone_temperature[z] = p.zone[z];
        end
    endtask

    task automatic check_phase_end(int idx, phase_t p);
        assert (lane_thermal[0].alarm === p.exp_alarm0 && system_alarm === p.exp_sys &&
                emergency_req === p.exp_emerg) else begin
            $display("MISMATCH phase %0d flags alarm0/system_alarm/emergency_req got 0x%0h",
                     idx, {lane_thermal[0].alarm, system_alarm, emergency_req});
            $display("MISMATCH phase %0d flags expected 0x%0h", idx,
                     {p.exp_alarm0, p.exp_sys, p.exp_emerg});
            phase_errors++;
        end
    endtask

    initial begin
        int total_cycles;
        #1;
        total_cycles = 0;
        for (int i = 0; i < NUM_PHASES; i++) begin
            total_cycles += int'(phases[i].cycles);
        end
        #((total_cycles + 50) * 20);
        $display("Watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h1639_4de2));
        cycle_errors = 0;
        phase_errors = 0;
        //                  corner     lanes  mW  zone0 zone1 on off gte en cyc al sys em
        phases[0] = make_phase(CORNER_TT, 8'hFF, 60, 300, 300, 90, 75, 0, 1, 100, 0, 0, 0);
        phases[1] = make_phase(CORNER_SS, 8'hFF, 150, 300, 300, 90, 75, 0, 1, 120, 1, 1, 1);
        phases[2] = make_phase(CORNER_TT, 8'hFF, 116, 300, 300, 90, 75, 0, 1, 120, 1, 0, 0);
        phases[3] = make_phase(CORNER_FF, 8'hFF, 100, 300, 300, 90, 75, 0, 1, 300, 0, 0, 0);
        phases[4] = make_phase(CORNER_TT, 8'hFF, 110, 300, 300, 78, 75, 1, 1, 300, 0, 0, 0);
        phases[5] = make_phase(CORNER_TT, 8'hFF, 60, 900, 1100, 90, 75, 0, 1, 60, 0, 1, 1);
        phases[6] = make_phase(CORNER_TT, 8'h0F, 140, 300, 300, 90, 75, 0, 1, 150, 1, 1, 0);
        phases[7] = make_phase(CORNER_SS, 8'hFF, 200, 300, 300, 60, 90, 1, 0, 50, 1, 1, 0);
        phases[8] = make_phase(CORNER_TT, 8'hFF, 20, 300, 300, 90, 75, 0, 1, 200, 0, 0, 0);

        apply_phase(phases[0]);
        thermal_enable = 1'b0;   // Idle until reset is gone
        @(posedge rst_n);
        @(posedge clk);
        #1;
        for (int l = 0; l < `NUM_LANES; l++) begin
            check_val("reset_temp", l, 32'(lane_thermal[l].temp), 32'(AMBIENT));
            check_val("reset_flags", l, 32'({lane_thermal[l].alarm, lane_thermal[l].critical}),
                      32'h0);
            check_val("reset_cmd", l, 32'(throttle_cmd[l]), 32'(IDLE_CMD));
        end
        check_val("reset_max_temp", 0, 32'(max_temp), 32'(AMBIENT));
        check_val("reset_zone_flags", 0, 32'({zone_alarm, zone_critical}), 32'h0);
        check_val("reset_total_power", 0, 32'(total_power), 32'h0);
        check_val("reset_system_flags", 0, 32'({system_alarm, emergency_req}), 32'h0);

        for (int i = 0; i < NUM_PHASES; i++) begin
            #1 apply_phase(phases[i]);
            for (int c = 0; c < int'(phases[i].cycles); c++) begin
                @(posedge clk);
                #1 check_outputs();
            end
            check_phase_end(i, phases[i]);
        end

        $display("Errors: per-cycle %0d, end-of-phase %0d", cycle_errors, phase_errors);
        if (cycle_errors == 0 && phase_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/thermal_pkg.sv
hw/power_pkg.sv
hw/power_derate.sv
hw/lane_thermal_model.sv
hw/throttle_ctrl.sv
hw/thermal_aggregate.sv
hw/thermal_manager_top.sv
sim/tb_clk_gen.sv
sim/tb_thermal_manager.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f compile.f --top-module tb_thermal_manager -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || grep -q "TB PASSED" sim.log || exit 1
exit 0
